/* hw/axi4_bus_pkg.sv */
// AXI4 bus widths, beat types and fixed AR field values, imported by the read engine RTL
package axi4_bus_pkg;

    // ------------------------------------------------------------
    // bus geometry
    // ------------------------------------------------------------
    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_DATA_SIZE  = 2;
    localparam int AXI_DATA_WIDTH = 8 << AXI_DATA_SIZE;
    localparam int AXI_LEN_WIDTH  = 8;
    localparam int AXI_ID_WIDTH   = 6;

    // ------------------------------------------------------------
    // constant AR fields
    // ------------------------------------------------------------
    localparam logic [AXI_ID_WIDTH-1:0] AXI_ARID     = '0;
    localparam logic [1:0]              AXI_ARBURST  = 2'b01;
    localparam logic [3:0]              AXI_ARCACHE  = 4'b0001;
    localparam logic [2:0]              AXI_ARPROT   = 3'b000;
    localparam logic [3:0]              AXI_ARQOS    = 4'b0000;
    localparam logic [3:0]              AXI_ARREGION = 4'b0000;
    localparam logic [0:0]              AXI_ARLOCK   = 1'b0;

    // byte address
    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
    // beats minus one
    typedef logic [AXI_LEN_WIDTH-1:0]  axi_len_t;
    typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;

endpackage

/* hw/read_core_pkg.sv */
// internal types of the burst read engine, shared by the command pipeline stages
package read_core_pkg;

    import axi4_bus_pkg::*;

    // 4 KB pages
    localparam int PAGE_BITS     = 12;
    localparam int REQ_LEN_WIDTH = 10;

    // user request length, words minus one
    typedef logic [REQ_LEN_WIDTH-1:0] req_len_t;

    // free FIFO words, must reach the full FIFO depth
    typedef logic [9:0] credit_t;

    // ------------------------------------------------------------
    // address seen as page number and page offset
    // ------------------------------------------------------------
    typedef struct packed {
        logic [AXI_ADDR_WIDTH-PAGE_BITS-1:0] page;
        logic [PAGE_BITS-1:0]                offset;
    } page_view_t;

    typedef union packed {
        axi_addr_t  flat;
        page_view_t paged;
    } page_addr_u;

endpackage

/* hw/burst_addr_gen.sv */
// splits one user read request into bursts no longer than the requested maximum length
`timescale 1ns/1ps

module burst_addr_gen (
    input  logic                    aclk,
    input  logic                    reset,

    input  axi4_bus_pkg::axi_addr_t s_addr,
    input  read_core_pkg::req_len_t s_len,
    input  axi4_bus_pkg::axi_len_t  s_max_len,
    input  logic                    s_valid,
    output logic                    s_ready,

    output axi4_bus_pkg::axi_addr_t m_addr,
    output axi4_bus_pkg::axi_len_t  m_len,
    output logic                    m_valid,
    input  logic                    m_ready
);

    import axi4_bus_pkg::*;
    import read_core_pkg::*;

    logic      busy;
    axi_addr_t cur_addr;
    req_len_t  remain;
    axi_len_t  max_len;

    axi_len_t  burst_len;
    logic      last_burst;

    // remaining words fit in one burst
    assign last_burst = (remain <= req_len_t'(max_len));
    assign burst_len  = last_burst ? axi_len_t'(remain) : max_len;

    assign s_ready = ~busy;
    assign m_addr  = cur_addr;
    assign m_len   = burst_len;
    assign m_valid = busy;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (s_valid && s_ready) begin
            busy <= 1'b1;
        end else if (m_valid && m_ready && last_burst) begin
            busy <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // address and word count
    // ------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (s_valid && s_ready) begin
            cur_addr <= s_addr;
            remain   <= s_len;
            max_len  <= s_max_len;
        end else if (m_valid && m_ready) begin
            // four bytes per word
            cur_addr <= cur_addr
                      + ((axi_addr_t'(burst_len) + axi_addr_t'(1)) << AXI_DATA_SIZE);
            remain   <= remain - req_len_t'(burst_len) - req_len_t'(1);
        end
    end

endmodule

/* hw/fifo_credit_gate.sv */
// holds bursts back until the read data FIFO has room for every beat they return
`timescale 1ns/1ps

module fifo_credit_gate #(
    parameter int FIFO_PTR_WIDTH = 6
) (
    input  logic                    aclk,
    input  logic                    reset,
    input  logic                    credit_pulse,

    input  axi4_bus_pkg::axi_addr_t s_addr,
    input  axi4_bus_pkg::axi_len_t  s_len,
    input  logic                    s_valid,
    output logic                    s_ready,

    output axi4_bus_pkg::axi_addr_t m_addr,
    output axi4_bus_pkg::axi_len_t  m_len,
    output logic                    m_valid,
    input  logic                    m_ready
);

    import read_core_pkg::*;

    // empty FIFO after reset
    localparam credit_t CREDIT_INIT = credit_t'(1 << FIFO_PTR_WIDTH);

    credit_t credit;
    credit_t beats;
    logic    has_room;
    logic    accept;

    assign beats    = credit_t'(s_len) + credit_t'(1);
    assign has_room = (credit >= beats);
    assign s_ready  = has_room && (!m_valid || m_ready);
    assign accept   = s_valid && s_ready;

    // ------------------------------------------------------------
    // free word count
    // ------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset) begin
            credit <= CREDIT_INIT;
        end else begin
            // beats reserved on issue, freed one per pop
            credit <= credit - (accept ? beats : credit_t'(0)) + credit_t'(credit_pulse);
        end
    end

    // ------------------------------------------------------------
    // output register
    // ------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset) begin
            m_valid <= 1'b0;
        end else if (accept) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            m_addr <= s_addr;
            m_len  <= s_len;
        end
    end

endmodule

/* hw/page_boundary_split.sv */
// splits any AXI4 read burst that would cross a page into a head and a tail burst
`timescale 1ns/1ps

module page_boundary_split #(
    parameter int PAGE_BITS = read_core_pkg::PAGE_BITS
) (
    input  logic                    aclk,
    input  logic                    reset,

    input  axi4_bus_pkg::axi_addr_t s_addr,
    input  axi4_bus_pkg::axi_len_t  s_len,
    input  logic                    s_valid,
    output logic                    s_ready,

    output axi4_bus_pkg::axi_addr_t m_addr,
    output axi4_bus_pkg::axi_len_t  m_len,
    output logic                    m_valid,
    input  logic                    m_ready
);

    import axi4_bus_pkg::*;
    import read_core_pkg::*;

    page_addr_u start_addr;
    page_addr_u end_addr;
    page_addr_u next_page;

    logic [PAGE_BITS-AXI_DATA_SIZE-1:0] word_offset;
    axi_len_t  head_len;
    logic      crossing;

    logic      tail_pending;
    axi_addr_t tail_addr;
    axi_len_t  tail_len;

    logic      accept;
    logic      out_done;

    // ------------------------------------------------------------
    // page decode
    // ------------------------------------------------------------
    assign start_addr = page_addr_u'(s_addr);
    assign end_addr   = page_addr_u'(s_addr + (axi_addr_t'(s_len) << AXI_DATA_SIZE));
    assign crossing   = (end_addr.paged.page != start_addr.paged.page);

    always_comb begin
        next_page.paged.page   = start_addr.paged.page + 1'b1;
        next_page.paged.offset = '0;
    end

    // words left in the page minus one, only meaningful when crossing
    assign word_offset = start_addr.paged.offset[PAGE_BITS-1:AXI_DATA_SIZE];
    assign head_len    = axi_len_t'(~word_offset);

    assign s_ready  = !tail_pending && (!m_valid || m_ready);
    assign accept   = s_valid && s_ready;
    assign out_done = m_valid && m_ready;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset) begin
            m_valid      <= 1'b0;
            tail_pending <= 1'b0;
        end else if (accept) begin
            m_valid      <= 1'b1;
            tail_pending <= crossing;
        end else if (out_done && tail_pending) begin
            tail_pending <= 1'b0;
        end else if (out_done) begin
            m_valid <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // burst payload
    // ------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (accept) begin
            m_addr    <= s_addr;
            m_len     <= crossing ? head_len : s_len;
            tail_addr <= next_page.flat;
            tail_len  <= s_len - head_len - axi_len_t'(1);
        end else if (out_done && tail_pending) begin
            m_addr <= tail_addr;
            m_len  <= tail_len;
        end
    end

endmodule

/* hw/read_data_fifo.sv */
// synchronous FIFO for AXI4 read data, pulses one credit back per word handed to the user
`timescale 1ns/1ps

module read_data_fifo #(
    parameter int FIFO_PTR_WIDTH = 6
) (
    input  logic                    aclk,
    input  logic                    reset,

    input  axi4_bus_pkg::axi_data_t wr_data,
    input  logic                    wr_valid,
    output logic                    wr_ready,

    output axi4_bus_pkg::axi_data_t rd_data,
    output logic                    rd_valid,
    input  logic                    rd_ready,

    output logic                    credit_pulse
);

    import axi4_bus_pkg::*;

    localparam int DEPTH = 1 << FIFO_PTR_WIDTH;

    axi_data_t mem [DEPTH];

    // extra bit tells full from empty
    logic [FIFO_PTR_WIDTH:0] wr_ptr;
    logic [FIFO_PTR_WIDTH:0] rd_ptr;

    logic full;
    logic empty;
    logic push;
    logic pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_PTR_WIDTH] != rd_ptr[FIFO_PTR_WIDTH])
                && (wr_ptr[FIFO_PTR_WIDTH-1:0] == rd_ptr[FIFO_PTR_WIDTH-1:0]);

    assign wr_ready = !full;
    assign rd_valid = !empty;
    assign push     = wr_valid && wr_ready;
    assign pop      = rd_valid && rd_ready;

    assign rd_data      = mem[rd_ptr[FIFO_PTR_WIDTH-1:0]];
    assign credit_pulse = pop;

    // ------------------------------------------------------------
    // pointers
    // ------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr[FIFO_PTR_WIDTH-1:0]] <= wr_data;
        end
    end

endmodule

/* hw/axi4_burst_reader.sv */
// top level of the AXI4 burst read engine, user request and data ports on one side, AXI4 AR/R on the other
`timescale 1ns/1ps

module axi4_burst_reader #(
    parameter int FIFO_PTR_WIDTH = 6
) (
    input  logic                                       aclk,
    input  logic                                       reset,

    input  axi4_bus_pkg::axi_addr_t                    s_araddr,
    input  read_core_pkg::req_len_t                    s_arlen,
    input  axi4_bus_pkg::axi_len_t                     s_arlen_max,
    input  logic                                       s_arvalid,
    output logic                                       s_arready,

    output axi4_bus_pkg::axi_data_t                    s_rdata,
    output logic                                       s_rvalid,
    input  logic                                       s_rready,

    output logic [axi4_bus_pkg::AXI_ID_WIDTH-1:0]      m_axi4_arid,
    output axi4_bus_pkg::axi_addr_t                    m_axi4_araddr,
    output axi4_bus_pkg::axi_len_t                     m_axi4_arlen,
    output logic [2:0]                                 m_axi4_arsize,
    output logic [1:0]                                 m_axi4_arburst,
    output logic [0:0]                                 m_axi4_arlock,
    output logic [3:0]                                 m_axi4_arcache,
    output logic [2:0]                                 m_axi4_arprot,
    output logic [3:0]                                 m_axi4_arqos,
    output logic [3:0]                                 m_axi4_arregion,
    output logic                                       m_axi4_arvalid,
    input  logic                                       m_axi4_arready,
    input  logic [axi4_bus_pkg::AXI_ID_WIDTH-1:0]      m_axi4_rid,
    input  axi4_bus_pkg::axi_data_t                    m_axi4_rdata,
    input  logic [1:0]                                 m_axi4_rresp,
    input  logic                                       m_axi4_rlast,
    input  logic                                       m_axi4_rvalid,
    output logic                                       m_axi4_rready
);

    import axi4_bus_pkg::*;

    // byte lanes below one word
    localparam axi_addr_t ADDR_MASK = axi_addr_t'((1 << AXI_DATA_SIZE) - 1);

    axi_addr_t gen_addr;
    axi_len_t  gen_len;
    logic      gen_valid;
    logic      gen_ready;

    axi_addr_t cap_addr;
    axi_len_t  cap_len;
    logic      cap_valid;
    logic      cap_ready;

    logic      credit_pulse;

    // ------------------------------------------------------------
    // command pipeline
    // ------------------------------------------------------------
    burst_addr_gen burst_addr_gen_i (
        .aclk      (aclk),
        .reset     (reset),
        .s_addr    (s_araddr & ~ADDR_MASK),
        .s_len     (s_arlen),
        .s_max_len (s_arlen_max),
        .s_valid   (s_arvalid),
        .s_ready   (s_arready),
        .m_addr    (gen_addr),
        .m_len     (gen_len),
        .m_valid   (gen_valid),
        .m_ready   (gen_ready)
    );

    fifo_credit_gate #(
        .FIFO_PTR_WIDTH (FIFO_PTR_WIDTH)
    ) fifo_credit_gate_i (
        .aclk         (aclk),
        .reset        (reset),
        .credit_pulse (credit_pulse),
        .s_addr       (gen_addr),
        .s_len        (gen_len),
        .s_valid      (gen_valid),
        .s_ready      (gen_ready),
        .m_addr       (cap_addr),
        .m_len        (cap_len),
        .m_valid      (cap_valid),
        .m_ready      (cap_ready)
    );

    page_boundary_split page_boundary_split_i (
        .aclk    (aclk),
        .reset   (reset),
        .s_addr  (cap_addr),
        .s_len   (cap_len),
        .s_valid (cap_valid),
        .s_ready (cap_ready),
        .m_addr  (m_axi4_araddr),
        .m_len   (m_axi4_arlen),
        .m_valid (m_axi4_arvalid),
        .m_ready (m_axi4_arready)
    );

    // fixed AR fields
    assign m_axi4_arid     = AXI_ARID;
    assign m_axi4_arsize   = 3'(AXI_DATA_SIZE);
    assign m_axi4_arburst  = AXI_ARBURST;
    assign m_axi4_arlock   = AXI_ARLOCK;
    assign m_axi4_arcache  = AXI_ARCACHE;
    assign m_axi4_arprot   = AXI_ARPROT;
    assign m_axi4_arqos    = AXI_ARQOS;
    assign m_axi4_arregion = AXI_ARREGION;

    // ------------------------------------------------------------
    // read data path
    // ------------------------------------------------------------
    // rid, rresp and rlast carry nothing the in-order stream needs
    read_data_fifo #(
        .FIFO_PTR_WIDTH (FIFO_PTR_WIDTH)
    ) read_data_fifo_i (
        .aclk         (aclk),
        .reset        (reset),
        .wr_data      (m_axi4_rdata),
        .wr_valid     (m_axi4_rvalid),
        .wr_ready     (m_axi4_rready),
        .rd_data      (s_rdata),
        .rd_valid     (s_rvalid),
        .rd_ready     (s_rready),
        .credit_pulse (credit_pulse)
    );

endmodule

/* bench/axi4_burst_reader_tb.sv */
// testbench for the AXI4 burst read engine that runs the requests listed in the tests file
`timescale 1ns/1ps

module axi4_burst_reader_tb;

    localparam int FIFO_PTR_WIDTH = 4;
    localparam int FIFO_DEPTH     = 16;
    localparam int MAX_TESTS      = 64;

    logic        aclk = 1'b0;
    logic        reset;
    logic [31:0] s_araddr;
    logic [9:0]  s_arlen;
    logic [7:0]  s_arlen_max;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_rdata;
    logic        s_rvalid;
    logic        s_rready;
    logic [5:0]  m_axi4_arid;
    logic [31:0] m_axi4_araddr;
    logic [7:0]  m_axi4_arlen;
    logic [2:0]  m_axi4_arsize;
    logic [1:0]  m_axi4_arburst;
    logic [0:0]  m_axi4_arlock;
    logic [3:0]  m_axi4_arcache;
    logic [2:0]  m_axi4_arprot;
    logic [3:0]  m_axi4_arqos;
    logic [3:0]  m_axi4_arregion;
    logic        m_axi4_arvalid;
    logic        m_axi4_arready;
    logic [5:0]  m_axi4_rid;
    logic [31:0] m_axi4_rdata;
    logic [1:0]  m_axi4_rresp;
    logic        m_axi4_rlast;
    logic        m_axi4_rvalid;
    logic        m_axi4_rready;

    logic [31:0] test_mem [0:4*MAX_TESTS-1];
    logic [31:0] exp_ar_addr [$];
    int          exp_ar_len [$];
    logic [31:0] exp_data [$];
    logic [31:0] slv_addr [$];
    int          slv_len [$];
    int          beat;
    int          outstanding;
    int          bp_mode;
    int          watchdog_cycles;
    int          value_errors;
    int          protocol_errors;
    logic [15:0] lfsr;

    always #10 aclk = ~aclk;

    axi4_burst_reader #(
        .FIFO_PTR_WIDTH (FIFO_PTR_WIDTH)
    ) dut_i (
        .aclk            (aclk),
        .reset           (reset),
        .s_araddr        (s_araddr),
        .s_arlen         (s_arlen),
        .s_arlen_max     (s_arlen_max),
        .s_arvalid       (s_arvalid),
        .s_arready       (s_arready),
        .s_rdata         (s_rdata),
        .s_rvalid        (s_rvalid),
        .s_rready        (s_rready),
        .m_axi4_arid     (m_axi4_arid),
        .m_axi4_araddr   (m_axi4_araddr),
        .m_axi4_arlen    (m_axi4_arlen),
        .m_axi4_arsize   (m_axi4_arsize),
        .m_axi4_arburst  (m_axi4_arburst),
        .m_axi4_arlock   (m_axi4_arlock),
        .m_axi4_arcache  (m_axi4_arcache),
        .m_axi4_arprot   (m_axi4_arprot),
        .m_axi4_arqos    (m_axi4_arqos),
        .m_axi4_arregion (m_axi4_arregion),
        .m_axi4_arvalid  (m_axi4_arvalid),
        .m_axi4_arready  (m_axi4_arready),
        .m_axi4_rid      (m_axi4_rid),
        .m_axi4_rdata    (m_axi4_rdata),
        .m_axi4_rresp    (m_axi4_rresp),
        .m_axi4_rlast    (m_axi4_rlast),
        .m_axi4_rvalid   (m_axi4_rvalid),
        .m_axi4_rready   (m_axi4_rready)
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        lfsr_step = {s[14:0], fb};
    endfunction

    task automatic value_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] expv);
        $display("FAILED t=%0t %s got %h expected %h", $time, sig, got, expv);
        value_errors++;
    endtask

    task automatic protocol_fault(input string what);
        $display("error at t=%0t: %s", $time, what);
        protocol_errors++;
    endtask

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    task automatic split_at_page(input logic [31:0] a, input int n);
        logic [31:0] last;
        int          head;
        last = a + 32'((n - 1) * 4);
        if (last[31:12] != a[31:12]) begin
            head = (4096 - int'(a[11:0])) / 4;
            exp_ar_addr.push_back(a);
            exp_ar_len.push_back(head - 1);
            exp_ar_addr.push_back({a[31:12] + 20'd1, 12'h000});
            exp_ar_len.push_back(n - head - 1);
        end else begin
            exp_ar_addr.push_back(a);
            exp_ar_len.push_back(n - 1);
        end
    endtask

    task automatic build_expected(input logic [31:0] addr, input int len, input int max);
        logic [31:0] a;
        int          remain;
        int          n;
        a = {addr[31:2], 2'b00};
        for (int i = 0; i <= len; i++) begin
            exp_data.push_back(a + 32'(i * 4));
        end
        remain = len + 1;
        while (remain > 0) begin
            n = (remain < max + 1) ? remain : max + 1;
            split_at_page(a, n);
            a = a + 32'(n * 4);
            remain = remain - n;
        end
    endtask

    task automatic run_request(input logic [31:0] addr, input logic [9:0] len,
                               input logic [7:0] max);
        build_expected(addr, int'(len), int'(max));
        @(negedge aclk);
        while (!s_arready) @(negedge aclk);
        s_araddr    = addr;
        s_arlen     = len;
        s_arlen_max = max;
        s_arvalid   = 1'b1;
        @(negedge aclk);
        s_arvalid = 1'b0;
        while (exp_data.size() != 0) @(negedge aclk);
        assert (s_arready) else protocol_fault("s_arready low after all words arrived");
    endtask

    // ------------------------------------------------------------
    // slave model and back-pressure on the falling edge
    // ------------------------------------------------------------
    always @(negedge aclk) begin
        if (bp_mode == 1) begin
            lfsr = lfsr_step(lfsr);
            s_rready = lfsr[0];
        end else begin
            s_rready = 1'b1;
        end
        if (bp_mode == 2) begin
            lfsr = lfsr_step(lfsr);
            m_axi4_arready = lfsr[0];
        end else begin
            m_axi4_arready = 1'b1;
        end
        if (!reset && slv_addr.size() != 0) begin
            m_axi4_rvalid = 1'b1;
            m_axi4_rdata  = slv_addr[0] + 32'(beat * 4);
            m_axi4_rlast  = (beat == slv_len[0]);
        end else begin
            m_axi4_rvalid = 1'b0;
            m_axi4_rlast  = 1'b0;
        end
    end

    // ------------------------------------------------------------
    // monitor and scoreboard
    // ------------------------------------------------------------
    always @(posedge aclk) begin : monitor
        logic [31:0] last;
        logic [31:0] expv;
        int          exp_len;
        if (!reset) begin
            if (m_axi4_arvalid && m_axi4_arready) begin
                assert (m_axi4_arid == 6'd0) else value_mismatch("m_axi4_arid", m_axi4_arid, 0);
                assert (m_axi4_arsize == 3'd2)
                    else value_mismatch("m_axi4_arsize", m_axi4_arsize, 2);
                assert (m_axi4_arburst == 2'b01)
                    else value_mismatch("m_axi4_arburst", m_axi4_arburst, 1);
                assert (m_axi4_arcache == 4'b0001)
                    else value_mismatch("m_axi4_arcache", m_axi4_arcache, 1);
                assert (m_axi4_arprot == 3'd0)
                    else value_mismatch("m_axi4_arprot", m_axi4_arprot, 0);
                assert (m_axi4_arqos == 4'd0) else value_mismatch("m_axi4_arqos", m_axi4_arqos, 0);
                assert (m_axi4_arregion == 4'd0)
                    else value_mismatch("m_axi4_arregion", m_axi4_arregion, 0);
                assert (m_axi4_arlock == 1'b0)
                    else value_mismatch("m_axi4_arlock", m_axi4_arlock, 0);
                last = m_axi4_araddr + (32'(m_axi4_arlen) << 2);
                assert (last[31:12] == m_axi4_araddr[31:12])
                    else protocol_fault("AR burst covers two 4 KB pages");
                if (exp_ar_addr.size() == 0) begin
                    protocol_fault("AR burst issued that no request asked for");
                end else begin
                    expv    = exp_ar_addr.pop_front();
                    exp_len = exp_ar_len.pop_front();
                    assert (m_axi4_araddr == expv)
                        else value_mismatch("m_axi4_araddr", m_axi4_araddr, expv);
                    assert (int'(m_axi4_arlen) == exp_len)
                        else value_mismatch("m_axi4_arlen", m_axi4_arlen, exp_len);
                end
                slv_addr.push_back(m_axi4_araddr);
                slv_len.push_back(int'(m_axi4_arlen));
                outstanding += int'(m_axi4_arlen) + 1;
            end
            // FIFO never full while the slave offers a beat
            if (m_axi4_rvalid) begin
                assert (m_axi4_rready)
                    else value_mismatch("m_axi4_rready", m_axi4_rready, 1);
            end
            if (m_axi4_rvalid && m_axi4_rready) begin
                if (beat == slv_len[0]) begin
                    void'(slv_addr.pop_front());
                    void'(slv_len.pop_front());
                    beat = 0;
                end else begin
                    beat++;
                end
            end
            if (s_rvalid && s_rready) begin
                if (exp_data.size() == 0) begin
                    protocol_fault("data word arrived with no word expected");
                end else begin
                    expv = exp_data.pop_front();
                    assert (s_rdata == expv) else value_mismatch("s_rdata", s_rdata, expv);
                end
                outstanding--;
            end
            assert (outstanding <= FIFO_DEPTH)
                else protocol_fault("more beats issued than the read FIFO can hold");
        end
    end

    // ------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge aclk);
        $display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
        $display("errors: %0d value mismatches, %0d protocol faults",
                 value_errors, protocol_errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int num_tests;
        int total_words;
        reset          = 1'b1;
        s_araddr       = '0;
        s_arlen        = '0;
        s_arlen_max    = '0;
        s_arvalid      = 1'b0;
        s_rready       = 1'b1;
        m_axi4_arready = 1'b1;
        m_axi4_rid     = '0;
        m_axi4_rdata   = '0;
        m_axi4_rresp   = '0;
        m_axi4_rlast   = 1'b0;
        m_axi4_rvalid  = 1'b0;
        beat            = 0;
        outstanding     = 0;
        bp_mode         = 0;
        value_errors    = 0;
        protocol_errors = 0;
        lfsr            = 16'd33119;

        $readmemh("bench/axi4_burst_reader_tests.txt", test_mem);
        num_tests   = 0;
        total_words = 0;
        while (num_tests < MAX_TESTS && !$isunknown(test_mem[4*num_tests])) begin
            total_words += int'(test_mem[4*num_tests+1]) + 1;
            num_tests++;
        end
        assert (num_tests > 0) else protocol_fault("no requests read from the tests file");
        watchdog_cycles = 200 + 20 * total_words;

        repeat (2) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;

        // idle state straight out of reset
        assert (s_arready) else value_mismatch("s_arready", s_arready, 1);
        assert (!m_axi4_arvalid) else value_mismatch("m_axi4_arvalid", m_axi4_arvalid, 0);
        assert (!s_rvalid) else value_mismatch("s_rvalid", s_rvalid, 0);
        assert (m_axi4_rready) else value_mismatch("m_axi4_rready", m_axi4_rready, 1);

        for (int t = 0; t < num_tests; t++) begin
            bp_mode = int'(test_mem[4*t+3]);
            run_request(test_mem[4*t], test_mem[4*t+1][9:0], test_mem[4*t+2][7:0]);
        end
        bp_mode = 0;

        // nothing left in flight
        @(negedge aclk);
        assert (exp_ar_addr.size() == 0) else protocol_fault("expected AR bursts never issued");
        assert (slv_addr.size() == 0) else protocol_fault("slave still holds unreturned beats");
        assert (outstanding == 0) else protocol_fault("issued beats and received words differ");
        assert (s_arready) else protocol_fault("s_arready low at the end of the run");

        $display("errors: %0d value mismatches, %0d protocol faults",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* axi4_burst_reader.f */
hw/axi4_bus_pkg.sv
hw/read_core_pkg.sv
hw/burst_addr_gen.sv
hw/fifo_credit_gate.sv
hw/page_boundary_split.sv
hw/read_data_fifo.sv
hw/axi4_burst_reader.sv
bench/axi4_burst_reader_tb.sv

/* bench/axi4_burst_reader_tests.txt */
// columns: start address, length in words minus one, max burst length minus one
// last column is back-pressure mode: 0 none, 1 random s_rready, 2 random m_axi4_arready
00000000 000 00 0
00000100 01f 07 0
00000203 010 0f 0
00000fe0 00f 0f 0
00001ff8 003 03 0
00002000 03f 0f 1
00003ff0 01f 0f 1
00004004 040 05 2
00007ffc 00a 0f 2
0000a001 0ff 0f 1
0000bfc6 02c 0b 2
00010ffc 001 01 0
0001f000 000 0f 1
00020f80 07f 0f 0
00031ffe 007 02 1
00040000 3ff 0f 2
fffff000 00f 03 0
